//--- filelist.f
src/axis2ahb_pkg.sv
src/axis_in_fifo.sv
src/axis2ahb.sv
src/ahb_sram.sv
src/axis2ahb_top.sv
test/tb_axis2ahb.sv

//--- Makefile
# Verilator flow for the stream-to-AHB bridge
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_axis2ahb
RTL_TOP   ?= axis2ahb_top
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_BIN   ?= sim_$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) \
		-o $(SIM_BIN) -f $(FILELIST)
	./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "no pass result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_axis2ahb.sv
// random self-checking testbench for axis2ahb_top with 1 wait state, 64 words, FIFO of 4
// the RAM has no reset, so the whole memory is written before any read
`timescale 1ns/1ps
`default_nettype none

module tb_axis2ahb;
   import axis2ahb_pkg::*;

   localparam int PERIOD_NS   = 40;
   localparam int MEM_WORDS   = 64;
   localparam int FIFO_DEPTH  = 4;
   localparam int WAIT_STATES = 1;
   localparam int MAX_LEN     = 16;
   localparam int ROUNDS      = 12;
   // fill writes, random write/read pairs and six directed commands
   localparam int NUM_CMDS    = MEM_WORDS / MAX_LEN + 2 * ROUNDS + 6;
   localparam int WATCHDOG_NS = NUM_CMDS * MAX_LEN * 20 * PERIOD_NS;

   logic        clk = 1'b0;
   logic        rst_n;
   cfg_wr_t     cfg_wr;
   logic        cfg_wr_valid;
   logic        cfg_wr_ready;
   cfg_rd_t     cfg_rd;
   logic        cfg_rd_valid;
   logic        cfg_rd_ready;
   axis_beat_t  in_beat;
   logic        in_valid;
   logic        in_ready;
   axis_beat_t  out_beat;
   logic        out_valid;
   logic        out_ready;
   logic        busy;
   integer      seed = 32'he5ac;
   int          errors = 0;
   int          checks = 0;
   logic [31:0] pkt [MAX_LEN];
   logic [31:0] model_mem [MEM_WORDS];

   always #(PERIOD_NS / 2) clk = ~clk;

   axis2ahb_top #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .MEM_WORDS  (MEM_WORDS),
      .WAIT_STATES(WAIT_STATES)
   ) DUT (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .cfg_wr_i      (cfg_wr),
      .cfg_wr_valid_i(cfg_wr_valid),
      .cfg_wr_ready_o(cfg_wr_ready),
      .cfg_rd_i      (cfg_rd),
      .cfg_rd_valid_i(cfg_rd_valid),
      .cfg_rd_ready_o(cfg_rd_ready),
      .in_beat_i     (in_beat),
      .in_valid_i    (in_valid),
      .in_ready_o    (in_ready),
      .out_beat_o    (out_beat),
      .out_valid_o   (out_valid),
      .out_ready_i   (out_ready),
      .busy_o        (busy)
   );

   task automatic check_beat(input axis_beat_t got, input axis_beat_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0d ns: %s data %h last %b, expected data %h last %b",
                  $time, what, got.tdata, got.tlast, exp.tdata, exp.tlast);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      checks++;
      if (got != exp) begin
         errors++;
         $display("Fail at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed) & 32'h7fff_ffff;
      return r % n;
   endfunction

   // pattern built from the full byte address
   function automatic logic [31:0] fill_word(input int word);
      logic [15:0] a;
      a = 16'(word * 4);
      return {~a, a};
   endfunction

   // only words inside the memory keep their data
   function automatic void model_write(input int word, input int nbeats);
      int i;
      for (i = 0; i < nbeats; i++) begin
         if (word + i < MEM_WORDS) model_mem[word + i] = pkt[i];
      end
   endfunction

   task automatic send_write_cmd(input int word);
      @(negedge clk);
      cfg_wr.addr  = 16'(word * 4);
      cfg_wr_valid = 1'b1;
      @(posedge clk);
      while (!cfg_wr_ready) @(posedge clk);
      @(negedge clk);
      cfg_wr_valid = 1'b0;
   endtask

   task automatic send_stream(input int nbeats);
      int i;
      for (i = 0; i < nbeats; i++) begin
         @(negedge clk);
         in_valid = 1'b0;
         // random idle cycles between beats
         while ((($random(seed)) & 3) == 0) @(negedge clk);
         in_beat.tdata = pkt[i];
         in_beat.tlast = (i == nbeats - 1);
         in_valid      = 1'b1;
         @(posedge clk);
         while (!in_ready) @(posedge clk);
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_idle();
      @(posedge clk);
      while (busy) @(posedge clk);
   endtask

   task automatic write_packet(input int word, input int nbeats);
      send_write_cmd(word);
      model_write(word, nbeats);
      send_stream(nbeats);
      wait_idle();
   endtask

   task automatic send_read_cmd(input logic [15:0] addr, input int nbeats);
      @(negedge clk);
      cfg_rd.addr  = addr;
      cfg_rd.len   = 16'(nbeats - 1);
      cfg_rd_valid = 1'b1;
      @(posedge clk);
      while (!cfg_rd_ready) @(posedge clk);
   endtask

   // takes beats under random back-pressure until the adapter goes idle
   task automatic collect_read(input logic [15:0] addr, input int nbeats, input int exp_beats);
      axis_beat_t exp;
      int         count;
      int         word;
      count = 0;
      word  = int'(addr >> 2);
      @(negedge clk);
      cfg_rd_valid = 1'b0;
      out_ready    = (($random(seed) & 3) != 0);
      @(posedge clk);
      while (busy) begin
         if (out_valid && out_ready) begin
            if (count < exp_beats) begin
               exp.tdata = model_mem[word + count];
               exp.tlast = (count == nbeats - 1);
               check_beat(out_beat, exp, "read beat");
            end
            count++;
         end
         @(negedge clk);
         out_ready = (($random(seed) & 3) != 0);
         @(posedge clk);
      end
      check_count(count, exp_beats, "read beat count");
   endtask

   task automatic read_packet(input int word, input int nbeats);
      send_read_cmd(16'(word * 4), nbeats);
      collect_read(16'(word * 4), nbeats, nbeats);
   endtask

   initial begin
      int          i;
      int          j;
      int          word;
      int          len;
      int          wait_cnt;
      logic [15:0] addr;
      rst_n        = 1'b0;
      cfg_wr       = '0;
      cfg_wr_valid = 1'b0;
      cfg_rd       = '0;
      cfg_rd_valid = 1'b0;
      in_beat      = '0;
      in_valid     = 1'b0;
      out_ready    = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      @(posedge clk);
      check_bit(busy, 1'b0, "busy_o after reset");
      check_bit(cfg_wr_ready, 1'b0, "cfg_wr_ready_o after reset");
      check_bit(cfg_rd_ready, 1'b0, "cfg_rd_ready_o after reset");
      check_bit(in_ready, 1'b0, "in_ready_o after reset");
      check_bit(out_valid, 1'b0, "out_valid_o after reset");
      wait_cnt = 0;
      while (!in_ready && wait_cnt < 4) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (!in_ready) begin
         errors++;
         $display("in_ready_o did not rise within 4 cycles after reset");
      end

      // known contents in every word
      for (i = 0; i < MEM_WORDS / MAX_LEN; i++) begin
         for (j = 0; j < MAX_LEN; j++) pkt[j] = fill_word(i * MAX_LEN + j);
         write_packet(i * MAX_LEN, MAX_LEN);
      end

      for (i = 0; i < ROUNDS; i++) begin
         len  = 1 + rand_below(MAX_LEN);
         word = rand_below(MEM_WORDS - len + 1);
         for (j = 0; j < len; j++) pkt[j] = $random(seed);
         write_packet(word, len);
         read_packet(word, len);
      end

      // read starting above the memory returns no data
      addr = 16'(MEM_WORDS * 4 + 4 * rand_below(16));
      len  = 1 + rand_below(MAX_LEN);
      send_read_cmd(addr, len);
      collect_read(addr, len, 0);
      len  = 1 + rand_below(MAX_LEN);
      read_packet(rand_below(MEM_WORDS - len + 1), len);

      // write running past the top word, tail beats get drained
      for (j = 0; j < 8; j++) pkt[j] = $random(seed);
      write_packet(MEM_WORDS - 4, 8);
      read_packet(MEM_WORDS - 4, 4);

      // both commands offered together
      len  = 1 + rand_below(MAX_LEN);
      word = rand_below(MEM_WORDS - len + 1);
      for (j = 0; j < len; j++) pkt[j] = $random(seed);
      @(negedge clk);
      cfg_wr.addr  = 16'(word * 4);
      cfg_rd.addr  = 16'(word * 4);
      cfg_rd.len   = 16'(len - 1);
      cfg_wr_valid = 1'b1;
      cfg_rd_valid = 1'b1;
      @(posedge clk);
      check_bit(cfg_wr_ready, 1'b1, "cfg_wr_ready_o with both commands valid");
      check_bit(cfg_rd_ready, 1'b0, "cfg_rd_ready_o with both commands valid");
      @(negedge clk);
      cfg_wr_valid = 1'b0;
      model_write(word, len);
      // read ready is watched from the write's first cycle on
      fork
         send_stream(len);
         begin
            @(posedge clk);
            while (!cfg_rd_ready) @(posedge clk);
            check_bit(busy, 1'b0, "busy_o when read command taken");
         end
      join
      collect_read(16'(word * 4), len, len);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("run did not finish within %0d ns, DUT stopped responding", WATCHDOG_NS);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- src/axis2ahb_top.sv
// stream buffer, AHB manager adapter and AHB memory in one pipeline
// DATA_WIDTH and ADDR_WIDTH must equal axis2ahb_pkg DATA_W and ADDR_W
// FIFO_DEPTH of 2 or more
`timescale 1ns/1ps
`default_nettype none

module axis2ahb_top #(
   parameter int DATA_WIDTH  = axis2ahb_pkg::DATA_W,
   parameter int ADDR_WIDTH  = axis2ahb_pkg::ADDR_W,
   parameter int FIFO_DEPTH  = 4,
   parameter int MEM_WORDS   = 64,
   parameter int WAIT_STATES = 1
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  axis2ahb_pkg::cfg_wr_t    cfg_wr_i,
   input  logic                     cfg_wr_valid_i,
   output logic                     cfg_wr_ready_o,
   input  axis2ahb_pkg::cfg_rd_t    cfg_rd_i,
   input  logic                     cfg_rd_valid_i,
   output logic                     cfg_rd_ready_o,
   input  axis2ahb_pkg::axis_beat_t in_beat_i,
   input  logic                     in_valid_i,
   output logic                     in_ready_o,
   output axis2ahb_pkg::axis_beat_t out_beat_o,
   output logic                     out_valid_o,
   input  logic                     out_ready_i,
   output logic                     busy_o
);
   import axis2ahb_pkg::*;

   axis_beat_t fifo_beat;
   logic       fifo_valid;
   logic       fifo_ready;
   ahb_req_t   ahb_req;
   ahb_rsp_t   ahb_rsp;

   axis_in_fifo #(
      .DEPTH(FIFO_DEPTH)
   ) u_fifo (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .beat_i (in_beat_i),
      .valid_i(in_valid_i),
      .ready_o(in_ready_o),
      .beat_o (fifo_beat),
      .valid_o(fifo_valid),
      .ready_i(fifo_ready)
   );

   axis2ahb #(
      .DATA_WIDTH(DATA_WIDTH),
      .ADDR_WIDTH(ADDR_WIDTH)
   ) u_adapter (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_wr_i      (cfg_wr_i),
      .cfg_wr_valid_i(cfg_wr_valid_i),
      .cfg_wr_ready_o(cfg_wr_ready_o),
      .cfg_rd_i      (cfg_rd_i),
      .cfg_rd_valid_i(cfg_rd_valid_i),
      .cfg_rd_ready_o(cfg_rd_ready_o),
      .in_beat_i     (fifo_beat),
      .in_valid_i    (fifo_valid),
      .in_ready_o    (fifo_ready),
      .out_beat_o    (out_beat_o),
      .out_valid_o   (out_valid_o),
      .out_ready_i   (out_ready_i),
      .ahb_req_o     (ahb_req),
      .ahb_rsp_i     (ahb_rsp),
      .busy_o        (busy_o)
   );

   ahb_sram #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .MEM_WORDS  (MEM_WORDS),
      .WAIT_STATES(WAIT_STATES)
   ) u_sram (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .ahb_req_i(ahb_req),
      .ahb_rsp_o(ahb_rsp)
   );

endmodule

`default_nettype wire

//--- src/ahb_sram.sv
// AHB subordinate word memory, full-width accesses only, no reset of contents
// word index at or above MEM_WORDS answers with the two-cycle error response
// MEM_WORDS * DATA_WIDTH/8 must fit in ADDR_WIDTH bits
`timescale 1ns/1ps
`default_nettype none

module ahb_sram #(
   parameter int DATA_WIDTH  = axis2ahb_pkg::DATA_W,
   parameter int ADDR_WIDTH  = axis2ahb_pkg::ADDR_W,
   parameter int MEM_WORDS   = 64,
   parameter int WAIT_STATES = 1
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  axis2ahb_pkg::ahb_req_t ahb_req_i,
   output axis2ahb_pkg::ahb_rsp_t ahb_rsp_o
);
   import axis2ahb_pkg::*;

   localparam int STRB_WIDTH = DATA_WIDTH / 8;
   localparam int BYTE_SHIFT = $clog2(STRB_WIDTH);
   localparam int IDX_W      = $clog2(MEM_WORDS);
   localparam int WCNT_W     = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];
   logic [ADDR_WIDTH-1:0] word_idx;
   logic [IDX_W-1:0]      dp_idx_q;
   logic [WCNT_W-1:0]     wcnt_q;
   logic                  dp_act_q;
   logic                  dp_wr_q;
   logic                  dp_err_q;
   logic                  err_first_q;
   logic                  in_range;
   logic                  accept;
   logic                  hready;
   logic                  hresp;
   logic                  wr_en;

   assign word_idx = ahb_req_i.haddr >> BYTE_SHIFT;
   assign in_range = (word_idx < ADDR_WIDTH'(MEM_WORDS));

   // IDLE, BUSY and no pending phase all complete with zero wait
   assign hready = !dp_act_q ? 1'b1 : (dp_err_q ? !err_first_q : (wcnt_q == '0));
   assign hresp  = dp_act_q & dp_err_q;
   assign accept = hready && (ahb_req_i.htrans == NONSEQ || ahb_req_i.htrans == SEQ);
   assign wr_en  = dp_act_q & hready & dp_wr_q & ~dp_err_q;

   assign ahb_rsp_o = '{hrdata: mem_q[dp_idx_q], hready: hready, hresp: hresp};

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dp_act_q    <= 1'b0;
         dp_wr_q     <= 1'b0;
         dp_err_q    <= 1'b0;
         err_first_q <= 1'b0;
         wcnt_q      <= '0;
      end else if (hready) begin
         // next data phase starts from the address phase seen now
         dp_act_q    <= accept;
         dp_wr_q     <= ahb_req_i.hwrite;
         dp_err_q    <= accept & ~in_range;
         err_first_q <= accept & ~in_range;
         wcnt_q      <= WCNT_W'(WAIT_STATES);
      end else begin
         err_first_q <= 1'b0;
         if (wcnt_q != '0) wcnt_q <= wcnt_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) dp_idx_q <= word_idx[IDX_W-1:0];
      if (wr_en) begin
         for (int b = 0; b < STRB_WIDTH; b++) begin
            if (ahb_req_i.hwstrb[b]) begin
               mem_q[dp_idx_q][8*b +: 8] <= ahb_req_i.hwdata[8*b +: 8];
            end
         end
      end
   end

   // error is always hready low then hready high, never alone
   a_err_second: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      hresp && !hready |=> hresp && hready);

   a_err_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      hresp && hready |-> $past(hresp && !hready));

endmodule

`default_nettype wire

//--- src/axis2ahb.sv
// AXI-Stream to AHB manager, undefined-length INCR bursts, full-width beats
// reads are issued one at a time so the single output register never overflows
// DATA_WIDTH and ADDR_WIDTH must equal the package defaults
`timescale 1ns/1ps
`default_nettype none

module axis2ahb #(
   parameter int DATA_WIDTH = axis2ahb_pkg::DATA_W,
   parameter int ADDR_WIDTH = axis2ahb_pkg::ADDR_W
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  axis2ahb_pkg::cfg_wr_t    cfg_wr_i,
   input  logic                     cfg_wr_valid_i,
   output logic                     cfg_wr_ready_o,
   input  axis2ahb_pkg::cfg_rd_t    cfg_rd_i,
   input  logic                     cfg_rd_valid_i,
   output logic                     cfg_rd_ready_o,
   input  axis2ahb_pkg::axis_beat_t in_beat_i,
   input  logic                     in_valid_i,
   output logic                     in_ready_o,
   output axis2ahb_pkg::axis_beat_t out_beat_o,
   output logic                     out_valid_o,
   input  logic                     out_ready_i,
   output axis2ahb_pkg::ahb_req_t   ahb_req_o,
   input  axis2ahb_pkg::ahb_rsp_t   ahb_rsp_i,
   output logic                     busy_o
);
   import axis2ahb_pkg::*;

   localparam int STRB_WIDTH = DATA_WIDTH / 8;
   localparam logic [ADDR_WIDTH-1:0] ADDR_STEP = ADDR_WIDTH'(STRB_WIDTH);

   adapter_state_e        state_q, state_d;
   htrans_e               htrans_q, htrans_d;
   logic [ADDR_WIDTH-1:0] haddr_q, haddr_d;
   logic                  hwrite_q, hwrite_d;
   logic [ADDR_WIDTH-1:0] len_q, len_d;
   logic                  drain_q, drain_d;
   logic                  out_valid_q, out_valid_d;
   logic                  dp_real_q;
   axis_beat_t            out_beat_q;
   logic [DATA_WIDTH-1:0] wbuf_q;
   logic [DATA_WIDTH-1:0] hwdata_q;
   logic [STRB_WIDTH-1:0] hwstrb_q;
   logic                  hready;
   logic                  addr_acc;
   logic                  err_first;
   logic                  pop;
   logic                  out_take;
   logic                  capture;
   logic                  wbuf_load;

   assign hready    = ahb_rsp_i.hready;
   assign addr_acc  = hready && (htrans_q == NONSEQ || htrans_q == SEQ);
   // first cycle of the two-cycle error response
   assign err_first = ahb_rsp_i.hresp & ~hready;
   assign pop       = in_valid_i & in_ready_o;
   assign out_take  = out_valid_q & out_ready_i;

   assign busy_o      = (state_q != WAIT_CONFIG);
   assign out_valid_o = out_valid_q;
   assign out_beat_o  = out_beat_q;
   assign ahb_req_o   = '{haddr: haddr_q, htrans: htrans_q, hwrite: hwrite_q,
                          hwdata: hwdata_q, hwstrb: hwstrb_q};

   always_comb begin
      state_d        = state_q;
      htrans_d       = htrans_q;
      haddr_d        = haddr_q;
      hwrite_d       = hwrite_q;
      len_d          = len_q;
      drain_d        = drain_q;
      out_valid_d    = out_valid_q & ~out_ready_i;
      capture        = 1'b0;
      wbuf_load      = 1'b0;
      in_ready_o     = 1'b0;
      cfg_wr_ready_o = 1'b0;
      cfg_rd_ready_o = 1'b0;

      // BUSY keeps the address of the next beat
      if (addr_acc) haddr_d = haddr_q + ADDR_STEP;

      case (state_q)
         WAIT_CONFIG: begin
            if (cfg_wr_valid_i) begin
               cfg_wr_ready_o = 1'b1;
               haddr_d        = cfg_wr_i.addr;
               hwrite_d       = 1'b1;
               state_d        = WAIT_DATA;
            end else if (cfg_rd_valid_i) begin
               cfg_rd_ready_o = 1'b1;
               haddr_d        = cfg_rd_i.addr;
               len_d          = cfg_rd_i.len;
               hwrite_d       = 1'b0;
               htrans_d       = NONSEQ;
               state_d        = TRANSFER;
            end
         end
         // first beat of a write opens the burst
         WAIT_DATA: begin
            in_ready_o = hready;
            if (pop) begin
               wbuf_load = 1'b1;
               htrans_d  = NONSEQ;
               state_d   = in_beat_i.tlast ? LAST_DATA : TRANSFER;
            end
         end
         TRANSFER: begin
            if (err_first) begin
               htrans_d = IDLE;
               drain_d  = hwrite_q;
               state_d  = ERROR;
            end else if (hwrite_q) begin
               in_ready_o = hready;
               if (pop) begin
                  wbuf_load = 1'b1;
                  htrans_d  = SEQ;
                  if (in_beat_i.tlast) state_d = LAST_DATA;
               end else if (hready) begin
                  htrans_d = BUSY;
               end
            end else if (hready) begin
               if (dp_real_q) begin
                  // read data lands in the output register
                  capture     = 1'b1;
                  out_valid_d = 1'b1;
                  if (len_q == '0) begin
                     htrans_d = IDLE;
                     state_d  = LAST_DATA;
                  end else begin
                     len_d    = len_q - 1'b1;
                     htrans_d = BUSY;
                  end
               end else if (htrans_q == BUSY && (!out_valid_q || out_ready_i)) begin
                  htrans_d = SEQ;
               end else if (addr_acc) begin
                  htrans_d = BUSY;
               end
            end
         end
         LAST_DATA: begin
            if (err_first) begin
               htrans_d = IDLE;
               drain_d  = 1'b0;
               state_d  = ERROR;
            end else if (hwrite_q) begin
               if (hready) begin
                  htrans_d = IDLE;
                  if (htrans_q == IDLE) state_d = WAIT_CONFIG;
               end
            end else if (out_take) begin
               state_d = WAIT_CONFIG;
            end
         end
         // a failed write discards beats up to its tlast
         ERROR: begin
            in_ready_o = drain_q;
            if (pop && in_beat_i.tlast) drain_d = 1'b0;
            if (hready && (!drain_q || (pop && in_beat_i.tlast))) begin
               state_d = WAIT_CONFIG;
            end
         end
         default: begin
            state_d = WAIT_CONFIG;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= WAIT_CONFIG;
         htrans_q    <= IDLE;
         haddr_q     <= '0;
         hwrite_q    <= 1'b0;
         len_q       <= '0;
         drain_q     <= 1'b0;
         out_valid_q <= 1'b0;
         dp_real_q   <= 1'b0;
      end else begin
         state_q     <= state_d;
         htrans_q    <= htrans_d;
         haddr_q     <= haddr_d;
         hwrite_q    <= hwrite_d;
         len_q       <= len_d;
         drain_q     <= drain_d;
         out_valid_q <= out_valid_d;
         if (hready) dp_real_q <= addr_acc;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wbuf_load) wbuf_q <= in_beat_i.tdata;
      // write data follows its address phase by one bus cycle
      if (hready) begin
         hwdata_q <= wbuf_q;
         hwstrb_q <= {STRB_WIDTH{addr_acc & hwrite_q}};
      end
      if (capture) begin
         out_beat_q.tdata <= ahb_rsp_i.hrdata;
         out_beat_q.tlast <= (len_q == '0);
      end
   end

   // a burst always opens with NONSEQ
   a_no_idle_to_seq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      htrans_q == IDLE |=> htrans_q != SEQ);

   a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_q && !out_ready_i |=> out_valid_q && out_beat_q === $past(out_beat_q));

endmodule

`default_nettype wire

//--- src/axis_in_fifo.sv
// stream beat buffer in front of the adapter, DEPTH must be 2 or more
// ready_o is registered, so it stays low for one cycle after reset
`timescale 1ns/1ps
`default_nettype none

module axis_in_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  axis2ahb_pkg::axis_beat_t beat_i,
   input  logic                     valid_i,
   output logic                     ready_o,
   output axis2ahb_pkg::axis_beat_t beat_o,
   output logic                     valid_o,
   input  logic                     ready_i
);
   import axis2ahb_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   axis_beat_t       mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic [CNT_W-1:0] count_d;
   logic             ready_q;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign push    = valid_i & ready_q;
   assign pop     = valid_o & ready_i;
   assign valid_o = (count_q != '0);
   assign ready_o = ready_q;
   assign beat_o  = mem_q[rd_ptr_q];

   always_comb begin
      count_d = count_q;
      if (push && !pop) begin
         count_d = count_q + 1'b1;
      end else if (pop && !push) begin
         count_d = count_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         ready_q  <= 1'b0;
      end else begin
         if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
         count_q <= count_d;
         // full next cycle blocks the producer
         ready_q <= (count_d != CNT_W'(DEPTH));
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) mem_q[wr_ptr_q] <= beat_i;
   end

   // registered ready must never admit a beat into a full buffer
   a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_i && ready_o |-> count_q < CNT_W'(DEPTH));

   // a pop always finds a stored beat, pointers differ unless full
   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop |-> (rd_ptr_q != wr_ptr_q) || (count_q == CNT_W'(DEPTH)));

endmodule

`default_nettype wire

//--- src/axis2ahb_pkg.sv
// shared types for the stream-to-AHB bridge
// struct widths are fixed by DATA_W and ADDR_W below, so module
// parameters DATA_WIDTH and ADDR_WIDTH must keep these values
`default_nettype none

package axis2ahb_pkg;

   localparam int unsigned DATA_W = 32;
   localparam int unsigned ADDR_W = 16;

   // AHB transfer types
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_e;

   typedef enum logic [2:0] {
      WAIT_CONFIG = 3'd0,
      WAIT_DATA   = 3'd1,
      TRANSFER    = 3'd2,
      LAST_DATA   = 3'd3,
      ERROR       = 3'd4
   } adapter_state_e;

   typedef struct packed {
      logic [DATA_W-1:0] tdata;
      logic              tlast;
   } axis_beat_t;

   // start byte address of a write
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
   } cfg_wr_t;

   // len is beats minus one
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [ADDR_W-1:0] len;
   } cfg_rd_t;

   typedef struct packed {
      logic [ADDR_W-1:0]   haddr;
      htrans_e             htrans;
      logic                hwrite;
      logic [DATA_W-1:0]   hwdata;
      logic [DATA_W/8-1:0] hwstrb;
   } ahb_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] hrdata;
      logic              hready;
      logic              hresp;
   } ahb_rsp_t;

endpackage

`default_nettype wire
